// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = deck_of_cards_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep '\.sv$$' $(FILELIST))
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
rtl/deck_pkg.sv
rtl/deal_ctrl_if.sv
rtl/deal_sequencer.sv
rtl/reveal_timer.sv
rtl/card_shuffler.sv
rtl/card_reveal.sv
rtl/deck_of_cards.sv
sim/deck_of_cards_tb.sv

// File: rtl/card_reveal.sv
module card_reveal (
    input  logic                          clock_400hz,
    input  logic                          reset,
    deal_ctrl_if.reveal                   ctrl,
    input  deck_pkg::rank_t               ranks [deck_pkg::num_slots],
    input  deck_pkg::suit_t               suits [deck_pkg::num_slots],
    output deck_pkg::rank_t               shown_rank,
    output deck_pkg::suit_t               shown_suit,
    output logic [deck_pkg::glyph_w-1:0]  display_0,
    output logic [deck_pkg::glyph_w-1:0]  display_1
);
    import deck_pkg::*;

    reveal_field_u field;

    function automatic logic [glyph_w-1:0] rank_glyph(input rank_t rank);
        case (rank)
            4'b0001: rank_glyph = 8'b11101111;
            4'b0010: rank_glyph = 8'b11011010;
            4'b0011: rank_glyph = 8'b11110010;
            4'b0100: rank_glyph = 8'b01100110;
            4'b0101: rank_glyph = 8'b10110110;
            4'b0110: rank_glyph = 8'b10111110;
            4'b0111: rank_glyph = 8'b11100100;
            4'b1000: rank_glyph = 8'b11111110;
            4'b1001: rank_glyph = 8'b11110110;
            4'b1010: rank_glyph = 8'b01101100;
            4'b1011: rank_glyph = 8'b11110001;
            4'b1100: rank_glyph = 8'b11010111;
            4'b1101: rank_glyph = 8'b11011101;
            4'b1110: rank_glyph = 8'b00000001;
            default: rank_glyph = 8'b11111111;
        endcase
    endfunction

    function automatic logic [glyph_w-1:0] suit_glyph(input suit_t suit);
        case (suit)
            3'b110:  suit_glyph = 8'b10010111;
            3'b111:  suit_glyph = 8'b01101111;
            3'b010:  suit_glyph = 8'b10111011;
            3'b001:  suit_glyph = 8'b10011101;
            3'b101:  suit_glyph = 8'b00000001;
            default: suit_glyph = 8'b11111111;
        endcase
    endfunction

    // field of the current phase, written through the view it is read by
    always_comb begin
        field = '0;
        if (ctrl.show_suit) begin
            field.suit_view.spare = 1'b0;
            field.suit_view.suit  = suits[ctrl.slot_sel];
        end else begin
            field.rank = ranks[ctrl.slot_sel];
        end
    end

    always_ff @(posedge clock_400hz) begin
        if (!reset) begin
            shown_rank <= rank_reset;
            shown_suit <= suit_reset;
            display_0  <= '0;
            display_1  <= '0;
        end else if (ctrl.reveal_step) begin
            // the other display keeps its glyph
            if (ctrl.show_suit) begin
                shown_suit <= field.suit_view.suit;
                display_1  <= suit_glyph(field.suit_view.suit);
            end else begin
                shown_rank <= field.rank;
                display_0  <= rank_glyph(field.rank);
            end
        end
    end

endmodule

// File: rtl/card_shuffler.sv
module card_shuffler (
    input  logic             clock_400hz,
    input  logic             reset,
    deal_ctrl_if.shuffler    ctrl,
    input  deck_pkg::rank_t  shown_rank,
    input  deck_pkg::suit_t  shown_suit,
    output deck_pkg::rank_t  ranks [deck_pkg::num_slots],
    output deck_pkg::suit_t  suits [deck_pkg::num_slots]
);
    import deck_pkg::*;

    logic [num_slots-1:0] rank_fb;
    logic [num_slots-1:0] suit_fb;

    // new low bit of each register
    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            rank_fb[i] = ranks[i][rank_tap_a[i]]
                       ^ ranks[i][rank_tap_b[i]]
                       ^ shown_rank[rank_mix[i]];
            suit_fb[i] = suits[i][suit_tap_a[i]]
                       ^ suits[i][suit_tap_b[i]]
                       ^ shown_suit[suit_mix[i]];
        end
    end

    always_ff @(posedge clock_400hz) begin
        if (!reset) begin
            for (int i = 0; i < num_slots; i++) begin
                ranks[i] <= rank_reset;
                suits[i] <= suit_reset;
            end
        end else if (ctrl.shuffle_en) begin
            for (int i = 0; i < num_slots; i++) begin
                ranks[i] <= {ranks[i][rank_w-2:0], rank_fb[i]};
                suits[i] <= {suits[i][suit_w-2:0], suit_fb[i]};
            end
        end
    end

endmodule

// File: rtl/deal_ctrl_if.sv
interface deal_ctrl_if;
    import deck_pkg::*;

    logic  shuffle_en;
    logic  reveal_step;
    slot_t slot_sel;
    logic  show_suit;

    modport sequencer (
        output shuffle_en,
        output reveal_step,
        output slot_sel,
        output show_suit
    );

    modport shuffler (
        input shuffle_en
    );

    modport reveal (
        input reveal_step,
        input slot_sel,
        input show_suit
    );

endinterface

// File: rtl/deal_sequencer.sv
module deal_sequencer (
    input  logic               clock_400hz,
    input  logic               reset,
    input  logic               control,
    input  logic               dwell_done,
    output logic               timer_restart,
    output logic               timer_run,
    deal_ctrl_if.sequencer     ctrl,
    output deck_pkg::turn_t    turn
);
    import deck_pkg::*;

    deal_state_e state;
    deal_state_e state_next;

    // every state follows control alone
    assign state_next = control ? deal_shuffle : deal_show;

    always_ff @(posedge clock_400hz) begin
        if (!reset) begin
            state <= deal_idle;
        end else begin
            state <= state_next;
        end
    end

    // a high control aborts the dwell and counting resumes on the first low cycle
    assign timer_restart = control;
    assign timer_run     = !control;

    assign ctrl.shuffle_en  = control;
    assign ctrl.reveal_step = dwell_done && (state == deal_show);

    always_ff @(posedge clock_400hz) begin
        if (!reset) begin
            turn <= turn_t'(1);
        end else if (ctrl.reveal_step) begin
            turn <= {turn[turn_w-2:0], turn[turn_w-1]};
        end
    end

    // even bits are rank phases and odd bits suit phases
    always_comb begin
        ctrl.slot_sel  = '0;
        ctrl.show_suit = 1'b0;
        for (int i = 0; i < turn_w; i++) begin
            if (turn[i]) begin
                ctrl.slot_sel  = slot_t'(i / 2);
                ctrl.show_suit = 1'(i % 2);
            end
        end
    end

    turn_onehot: assert property (@(posedge clock_400hz) disable iff (!reset)
        $onehot(turn));

    no_step_in_shuffle: assert property (@(posedge clock_400hz) disable iff (!reset)
        ctrl.reveal_step |-> !ctrl.shuffle_en);

endmodule

// File: rtl/deck_of_cards.sv
module deck_of_cards (
    input  logic                                clock_400hz,
    input  logic                                reset,
    input  logic                                control,
    output logic [deck_pkg::turn_w-1:0]         turn,
    output logic [deck_pkg::glyph_w-1:0]        display_0,
    output logic [deck_pkg::glyph_w-1:0]        display_1,
    output logic [deck_pkg::rank_w-1:0]         face_card_number,
    output logic [deck_pkg::rank_w-1:0]         face_card_number_0,
    output logic [deck_pkg::rank_w-1:0]         face_card_number_1,
    output logic [deck_pkg::rank_w-1:0]         face_card_number_2,
    output logic [deck_pkg::rank_w-1:0]         face_card_number_3,
    output logic [deck_pkg::suit_w-1:0]         suits,
    output logic [deck_pkg::suit_w-1:0]         suits_0,
    output logic [deck_pkg::suit_w-1:0]         suits_1,
    output logic [deck_pkg::suit_w-1:0]         suits_2,
    output logic [deck_pkg::suit_w-1:0]         suits_3
);
    import deck_pkg::*;

    logic  dwell_done;
    logic  timer_restart;
    logic  timer_run;
    rank_t ranks [num_slots];
    suit_t slot_suits [num_slots];

    deal_ctrl_if ctrl_bus ();

    deal_sequencer u_sequencer (
        .clock_400hz   (clock_400hz),
        .reset         (reset),
        .control       (control),
        .dwell_done    (dwell_done),
        .timer_restart (timer_restart),
        .timer_run     (timer_run),
        .ctrl          (ctrl_bus.sequencer),
        .turn          (turn)
    );

    reveal_timer u_timer (
        .clock_400hz (clock_400hz),
        .reset       (reset),
        .restart     (timer_restart),
        .run         (timer_run),
        .dwell_done  (dwell_done)
    );

    // shown card feeds back into the shuffle
    card_shuffler u_shuffler (
        .clock_400hz (clock_400hz),
        .reset       (reset),
        .ctrl        (ctrl_bus.shuffler),
        .shown_rank  (face_card_number),
        .shown_suit  (suits),
        .ranks       (ranks),
        .suits       (slot_suits)
    );

    card_reveal u_reveal (
        .clock_400hz (clock_400hz),
        .reset       (reset),
        .ctrl        (ctrl_bus.reveal),
        .ranks       (ranks),
        .suits       (slot_suits),
        .shown_rank  (face_card_number),
        .shown_suit  (suits),
        .display_0   (display_0),
        .display_1   (display_1)
    );

    assign face_card_number_0 = ranks[0];
    assign face_card_number_1 = ranks[1];
    assign face_card_number_2 = ranks[2];
    assign face_card_number_3 = ranks[3];
    assign suits_0            = slot_suits[0];
    assign suits_1            = slot_suits[1];
    assign suits_2            = slot_suits[2];
    assign suits_3            = slot_suits[3];

endmodule

// File: rtl/deck_pkg.sv
package deck_pkg;

    localparam int num_slots   = 4;
    localparam int rank_w      = 4;
    localparam int suit_w      = 3;
    localparam int turn_w      = 2 * num_slots;
    localparam int glyph_w     = 8;
    localparam int dwell_ticks = 100;
    localparam int dwell_w     = $clog2(dwell_ticks);

    localparam logic [rank_w-1:0] rank_reset = 4'b1000;
    localparam logic [suit_w-1:0] suit_reset = 3'b100;

    // feedback taps per slot, two own bits plus one bit of the shown card
    localparam int rank_tap_a [num_slots] = '{0, 1, 2, 0};
    localparam int rank_tap_b [num_slots] = '{2, 3, 3, 3};
    localparam int rank_mix   [num_slots] = '{0, 1, 2, 3};
    localparam int suit_tap_a [num_slots] = '{0, 0, 1, 0};
    localparam int suit_tap_b [num_slots] = '{1, 2, 2, 2};
    localparam int suit_mix   [num_slots] = '{0, 1, 2, 0};

    typedef logic [rank_w-1:0] rank_t;
    typedef logic [suit_w-1:0] suit_t;

    typedef logic [$clog2(num_slots)-1:0] slot_t;

    // one bit per deal phase
    typedef logic [turn_w-1:0] turn_t;

    // revealed field, rank view or suit view of the same word
    typedef union packed {
        rank_t rank;
        struct packed {
            logic  spare;
            suit_t suit;
        } suit_view;
    } reveal_field_u;

    typedef enum logic [1:0] {
        deal_idle    = 2'd0,
        deal_shuffle = 2'd1,
        deal_show    = 2'd2
    } deal_state_e;

endpackage

// File: rtl/reveal_timer.sv
module reveal_timer (
    input  logic clock_400hz,
    input  logic reset,
    input  logic restart,
    input  logic run,
    output logic dwell_done
);
    import deck_pkg::*;

    logic [dwell_w-1:0] count;

    assign dwell_done = run && (count == dwell_w'(dwell_ticks - 1));

    always_ff @(posedge clock_400hz) begin
        if (!reset || restart) begin
            count <= '0;
        end else if (run) begin
            // wrap so the next phase gets a full dwell
            if (dwell_done) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    single_pulse: assert property (@(posedge clock_400hz) disable iff (!reset)
        dwell_done |=> !dwell_done);

endmodule

// File: sim/deck_of_cards_tb.sv
module deck_of_cards_tb;
    import deck_pkg::*;

    logic       clock_400hz;
    logic       reset;
    logic       control;
    logic [7:0] turn;
    logic [7:0] display_0;
    logic [7:0] display_1;
    logic [3:0] face_card_number;
    logic [2:0] suits;
    logic [3:0] dut_ranks [4];
    logic [2:0] dut_suits [4];

    // rank glyphs at 0..15, suit glyphs at 16..23, script rows from 24
    logic [7:0] testdata [0:127];

    logic [3:0] m_ranks [4];
    logic [2:0] m_suits [4];
    logic [3:0] m_shown_rank;
    logic [2:0] m_shown_suit;
    logic [7:0] m_turn;
    logic [7:0] m_display_0;
    logic [7:0] m_display_1;

    int     checks;
    int     errors;
    int     timeouts;
    integer seed;

    deck_of_cards uut (
        .clock_400hz        (clock_400hz),
        .reset              (reset),
        .control            (control),
        .turn               (turn),
        .display_0          (display_0),
        .display_1          (display_1),
        .face_card_number   (face_card_number),
        .face_card_number_0 (dut_ranks[0]),
        .face_card_number_1 (dut_ranks[1]),
        .face_card_number_2 (dut_ranks[2]),
        .face_card_number_3 (dut_ranks[3]),
        .suits              (suits),
        .suits_0            (dut_suits[0]),
        .suits_1            (dut_suits[1]),
        .suits_2            (dut_suits[2]),
        .suits_3            (dut_suits[3])
    );

    initial begin
        clock_400hz = 1'b0;
        forever #50 clock_400hz = ~clock_400hz;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("turn", turn, m_turn);
        check_value("display_0", display_0, m_display_0);
        check_value("display_1", display_1, m_display_1);
        check_value("face_card_number", face_card_number, m_shown_rank);
        check_value("suits", suits, m_shown_suit);
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("face_card_number_%0d", i), dut_ranks[i], m_ranks[i]);
            check_value($sformatf("suits_%0d", i), dut_suits[i], m_suits[i]);
        end
    endtask

    // shift left, new low bit from two own taps and one shown bit
    task automatic model_shuffle();
        m_ranks[0] = {m_ranks[0][2:0], m_ranks[0][0] ^ m_ranks[0][2] ^ m_shown_rank[0]};
        m_ranks[1] = {m_ranks[1][2:0], m_ranks[1][1] ^ m_ranks[1][3] ^ m_shown_rank[1]};
        m_ranks[2] = {m_ranks[2][2:0], m_ranks[2][2] ^ m_ranks[2][3] ^ m_shown_rank[2]};
        m_ranks[3] = {m_ranks[3][2:0], m_ranks[3][0] ^ m_ranks[3][3] ^ m_shown_rank[3]};
        m_suits[0] = {m_suits[0][1:0], m_suits[0][0] ^ m_suits[0][1] ^ m_shown_suit[0]};
        m_suits[1] = {m_suits[1][1:0], m_suits[1][0] ^ m_suits[1][2] ^ m_shown_suit[1]};
        m_suits[2] = {m_suits[2][1:0], m_suits[2][1] ^ m_suits[2][2] ^ m_shown_suit[2]};
        m_suits[3] = {m_suits[3][1:0], m_suits[3][0] ^ m_suits[3][2] ^ m_shown_suit[0]};
    endtask

    // even turn bit shows a rank, odd bit a suit
    task automatic model_reveal();
        int phase;
        int slot;
        phase = 0;
        for (int i = 0; i < 8; i++) begin
            if (m_turn[i]) phase = i;
        end
        slot = phase / 2;
        if (phase % 2 == 0) begin
            m_shown_rank = m_ranks[slot];
            m_display_0  = testdata[m_ranks[slot]];
        end else begin
            m_shown_suit = m_suits[slot];
            m_display_1  = testdata[16 + m_suits[slot]];
        end
        m_turn = {m_turn[6:0], m_turn[7]};
    endtask

    task automatic shuffle_cycles(input int n);
        control = (n > 0);
        for (int c = 0; c < n; c++) begin
            @(negedge clock_400hz);
            model_shuffle();
            check_outputs();
        end
        control = 1'b0;
    endtask

    task automatic deal_phase();
        logic [7:0] prev;
        int         cycles;
        prev   = turn;
        cycles = 0;
        while (turn === prev && cycles < 3 * dwell_ticks) begin
            @(negedge clock_400hz);
            cycles++;
        end
        if (turn === prev) begin
            timeouts++;
            $display("timeout: turn did not change within %0d cycles", 3 * dwell_ticks);
        end else begin
            check_value("turn_gap", cycles, dwell_ticks);
            model_reveal();
            check_outputs();
        end
    endtask

    initial begin
        int row;
        int n_random;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        seed     = 32'h25b48689;
        reset    = 1'b0;
        control  = 1'b0;
        $readmemh("sim/deck_testdata.txt", testdata);
        for (int i = 0; i < 4; i++) begin
            m_ranks[i] = 4'b1000;
            m_suits[i] = 3'b100;
        end
        m_shown_rank = 4'b1000;
        m_shown_suit = 3'b100;
        m_turn       = 8'h01;
        m_display_0  = 8'h00;
        m_display_1  = 8'h00;
        repeat (10) @(negedge clock_400hz);
        check_outputs();
        reset = 1'b1;

        // rows of high cycles, deal phases, and low cycles of an aborted dwell
        row = 24;
        while (timeouts == 0 && row < 120 && (testdata[row] != 0 || testdata[row + 1] != 0)) begin
            shuffle_cycles(testdata[row]);
            for (int p = 0; p < testdata[row + 1] && timeouts == 0; p++) begin
                deal_phase();
            end
            for (int c = 0; c < testdata[row + 2] && timeouts == 0; c++) begin
                @(negedge clock_400hz);
                check_outputs();
            end
            row += 3;
        end

        // long random shuffle, then all four cards dealt
        if (timeouts == 0) begin
            n_random = 256 + ($unsigned($random(seed)) % 512);
            shuffle_cycles(n_random);
            for (int p = 0; p < 8 && timeouts == 0; p++) begin
                deal_phase();
            end
        end

        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/deck_testdata.txt
// rank glyphs for codes 0-f, then suit glyphs for codes 0-7
// script rows after that: high cycles, low deal phases, low cycles of an aborted dwell
ff ef da f2 66 b6 be e4
fe f6 6c f1 d7 dd 01 ff
ff 9d bb ff ff 01 97 6f
// first row deals straight out of reset
00 03 1e
05 04 00
0c 02 50
01 05 0a
07 08 00
20 06 63
03 03 00
// zero row ends the script
00 00 00
